// File: src/core_pkg.sv
package core_pkg;

	// datapath widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	typedef logic [XLEN-1:0]       word_t;     // data word, address or instruction
	typedef logic [REG_ADDR_W-1:0] reg_addr_t; // register index
	typedef logic [3:0]            alu_op_t;
	typedef logic [1:0]            wb_sel_t;   // writeback source
	typedef logic [1:0]            fwd_sel_t;  // operand bypass choice
	typedef logic [6:0]            opcode_t;
	typedef logic [2:0]            funct3_t;

	// alu operation codes
	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_AND    = 4'd2;
	localparam alu_op_t ALU_OR     = 4'd3;
	localparam alu_op_t ALU_XOR    = 4'd4;
	localparam alu_op_t ALU_SLT    = 4'd5;
	localparam alu_op_t ALU_SLTU   = 4'd6;
	localparam alu_op_t ALU_SLL    = 4'd7;
	localparam alu_op_t ALU_SRL    = 4'd8;
	localparam alu_op_t ALU_SRA    = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10; // lui, operand b straight through

	// writeback sources
	localparam wb_sel_t WB_ALU  = 2'd0;
	localparam wb_sel_t WB_MEM  = 2'd1;
	localparam wb_sel_t WB_LINK = 2'd2; // pc + 4 for jal

	// bypass choices, mem beats wb
	localparam fwd_sel_t FWD_NONE = 2'd0;
	localparam fwd_sel_t FWD_MEM  = 2'd1;
	localparam fwd_sel_t FWD_WB   = 2'd2;

	// rv32i major opcodes kept in this core
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;

	// branch funct3 values
	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;
	localparam funct3_t F3_BLT = 3'b100;

	localparam word_t NOP_INSTR    = 32'h0000_0013; // addi x0,x0,0
	localparam word_t RESET_VECTOR = 32'h0000_0000;
	localparam word_t INSTR_BYTES  = 32'd4;

endpackage

// File: src/core_if.sv
`timescale 1ns/1ps

// decode -> execute pipeline register
interface idex_if;
	logic                valid;       // low for bubbles
	core_pkg::word_t     pc;
	core_pkg::reg_addr_t rs1, rs2, rd;
	core_pkg::word_t     rs1_data, rs2_data;
	core_pkg::word_t     imm;
	core_pkg::alu_op_t   alu_op;
	logic                alu_src_imm; // operand b from imm
	logic                is_branch;
	core_pkg::funct3_t   branch_cond;
	logic                is_jump;
	logic                mem_read, mem_write;
	logic                reg_write;
	core_pkg::wb_sel_t   wb_sel;

	modport decode (output valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
		alu_src_imm, is_branch, branch_cond, is_jump, mem_read, mem_write, reg_write, wb_sel);
	modport execute (input valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
		alu_src_imm, is_branch, branch_cond, is_jump, mem_read, mem_write, reg_write, wb_sel);
endinterface

// execute -> memory pipeline register
interface exmem_if;
	core_pkg::word_t     alu_result; // also the load address
	core_pkg::word_t     link_pc;
	core_pkg::reg_addr_t rd;
	logic                reg_write;
	logic                mem_read;
	core_pkg::wb_sel_t   wb_sel;

	modport execute (output alu_result, link_pc, rd, reg_write, mem_read, wb_sel);
	modport memwb (input alu_result, link_pc, rd, reg_write, mem_read, wb_sel);
	modport hazard (input rd, mem_read, reg_write);
endinterface

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic            clk_i,
	input  logic            reset_i,
	input  core_pkg::word_t instr_i,
	input  logic            stall_i,       // hold pc and if/id
	input  logic            redirect_i,    // branch/jal taken in ex
	input  core_pkg::word_t redirect_pc_i,
	output core_pkg::word_t instr_addr_o,
	output core_pkg::word_t ifid_instr_o,
	output core_pkg::word_t ifid_pc_o
);

	core_pkg::word_t pc_q;    // address being fetched this cycle
	core_pkg::word_t pc_next;

	// redirect beats stall which beats the sequential step
	always_comb
	begin
		if (redirect_i)
			pc_next = redirect_pc_i;
		else if (stall_i)
			pc_next = pc_q;
		else
			pc_next = pc_q + core_pkg::INSTR_BYTES;
	end

	// imem is combinational so instr_i belongs to pc_q
	assign instr_addr_o = pc_q;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q         <= core_pkg::RESET_VECTOR;
			ifid_instr_o <= core_pkg::NOP_INSTR;   // bubble out of reset
		end
		else
		begin
			pc_q <= pc_next;
			if (redirect_i)
				ifid_instr_o <= core_pkg::NOP_INSTR; // squash wrong-path fetch
			else if (!stall_i)
				ifid_instr_o <= instr_i;
		end
	end

	// pc of the instruction held in if/id
	always_ff @(posedge clk_i)
	begin
		if (!stall_i)
			ifid_pc_o <= pc_q;
	end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                clk_i,
	input  logic                reset_i,
	input  core_pkg::word_t     ifid_instr_i,
	input  core_pkg::word_t     ifid_pc_i,
	input  logic                redirect_i,
	input  logic                wb_write_i,
	input  core_pkg::reg_addr_t wb_rd_i,
	input  core_pkg::word_t     wb_data_i,
	output logic                stall_o,    // one-cycle load-use hold
	idex_if.decode              idex,
	exmem_if.hazard             exmem
);

	core_pkg::word_t     regs [core_pkg::NUM_REGS]; // x0 never written
	core_pkg::opcode_t   opcode;
	core_pkg::funct3_t   funct3;
	core_pkg::reg_addr_t rs1, rs2, rd;
	core_pkg::word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
	core_pkg::word_t     imm;
	core_pkg::alu_op_t   alu_op;
	core_pkg::wb_sel_t   wb_sel;
	logic                alu_src_imm, is_branch, is_jump;
	logic                mem_read, mem_write, reg_write;
	logic                uses_rs1, uses_rs2;
	logic                bubble;

	// funct3 to alu op
	// alt is instr[30] and picks sub only in the reg-reg form
	function automatic core_pkg::alu_op_t alu_decode(input core_pkg::funct3_t f3,
		input logic alt, input logic is_reg);
		case (f3)
			3'b000:  alu_decode = (alt && is_reg) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			3'b001:  alu_decode = core_pkg::ALU_SLL;
			3'b010:  alu_decode = core_pkg::ALU_SLT;
			3'b011:  alu_decode = core_pkg::ALU_SLTU;
			3'b100:  alu_decode = core_pkg::ALU_XOR;
			3'b101:  alu_decode = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			3'b110:  alu_decode = core_pkg::ALU_OR;
			default: alu_decode = core_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = ifid_instr_i[6:0];
	assign funct3 = ifid_instr_i[14:12];
	assign rd     = ifid_instr_i[11:7];
	assign rs1    = ifid_instr_i[19:15];
	assign rs2    = ifid_instr_i[24:20];

	// immediates sign extended from bit 31 except u
	assign imm_i = {{20{ifid_instr_i[31]}}, ifid_instr_i[31:20]};
	assign imm_s = {{20{ifid_instr_i[31]}}, ifid_instr_i[31:25], ifid_instr_i[11:7]};
	assign imm_b = {{19{ifid_instr_i[31]}}, ifid_instr_i[31], ifid_instr_i[7],
		ifid_instr_i[30:25], ifid_instr_i[11:8], 1'b0};
	assign imm_u = {ifid_instr_i[31:12], 12'b0};
	assign imm_j = {{11{ifid_instr_i[31]}}, ifid_instr_i[31], ifid_instr_i[19:12],
		ifid_instr_i[20], ifid_instr_i[30:21], 1'b0};

	always_comb
	begin
		alu_op      = core_pkg::ALU_ADD; // add is also the address adder
		alu_src_imm = 1'b0;
		is_branch   = 1'b0;
		is_jump     = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		reg_write   = 1'b0;
		wb_sel      = core_pkg::WB_ALU;
		imm         = imm_i;
		uses_rs1    = 1'b0;
		uses_rs2    = 1'b0;
		case (opcode)
			core_pkg::OPC_OP:
			begin
				alu_op    = alu_decode(funct3, ifid_instr_i[30], 1'b1);
				reg_write = 1'b1;
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
			end
			core_pkg::OPC_OP_IMM:
			begin
				alu_op      = alu_decode(funct3, ifid_instr_i[30], 1'b0);
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				uses_rs1    = 1'b1;
			end
			core_pkg::OPC_LUI:
			begin
				alu_op      = core_pkg::ALU_PASS_B;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				imm         = imm_u;
			end
			core_pkg::OPC_LOAD:
			begin
				alu_src_imm = 1'b1;
				mem_read    = 1'b1;
				reg_write   = 1'b1;
				wb_sel      = core_pkg::WB_MEM;
				uses_rs1    = 1'b1;
			end
			core_pkg::OPC_STORE:
			begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
				imm         = imm_s;
				uses_rs1    = 1'b1;
				uses_rs2    = 1'b1; // store data
			end
			core_pkg::OPC_BRANCH:
			begin
				is_branch = 1'b1;
				imm       = imm_b;
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
			end
			core_pkg::OPC_JAL:
			begin
				is_jump   = 1'b1;
				reg_write = 1'b1;
				wb_sel    = core_pkg::WB_LINK;
				imm       = imm_j;
			end
			default: ; // unsupported opcodes decode as a nop
		endcase
	end

	// regfile written mid-cycle so decode sees this cycle's writeback
	always_ff @(negedge clk_i)
	begin
		if (wb_write_i && (wb_rd_i != '0))
			regs[wb_rd_i] <= wb_data_i;
	end

	// load in ex whose rd the instruction here reads
	assign stall_o = idex.valid && idex.mem_read && (idex.rd != '0) &&
		((uses_rs1 && (idex.rd == rs1)) || (uses_rs2 && (idex.rd == rs2)));
	assign bubble = stall_o || redirect_i;

	// id/ex control cleared for bubbles
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			idex.valid       <= 1'b0;
			idex.alu_op      <= core_pkg::ALU_ADD;
			idex.alu_src_imm <= 1'b0;
			idex.is_branch   <= 1'b0;
			idex.is_jump     <= 1'b0;
			idex.mem_read    <= 1'b0;
			idex.mem_write   <= 1'b0;
			idex.reg_write   <= 1'b0;
			idex.wb_sel      <= core_pkg::WB_ALU;
		end
		else
		begin
			idex.valid       <= !bubble;
			idex.alu_op      <= bubble ? core_pkg::ALU_ADD : alu_op;
			idex.alu_src_imm <= !bubble && alu_src_imm;
			idex.is_branch   <= !bubble && is_branch;
			idex.is_jump     <= !bubble && is_jump;
			idex.mem_read    <= !bubble && mem_read;
			idex.mem_write   <= !bubble && mem_write;
			idex.reg_write   <= !bubble && reg_write;
			idex.wb_sel      <= bubble ? core_pkg::WB_ALU : wb_sel;
		end
	end

	// id/ex payload
	always_ff @(posedge clk_i)
	begin
		idex.pc          <= ifid_pc_i;
		idex.rs1         <= rs1;
		idex.rs2         <= rs2;
		idex.rd          <= rd;
		idex.rs1_data    <= (rs1 == '0) ? '0 : regs[rs1];
		idex.rs2_data    <= (rs2 == '0) ? '0 : regs[rs2];
		idex.imm         <= imm;
		idex.branch_cond <= funct3;
	end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                wb_write_i,
	input  core_pkg::reg_addr_t wb_rd_i,
	input  core_pkg::word_t     wb_data_i,
	output logic                redirect_o,
	output core_pkg::word_t     redirect_pc_o,
	output core_pkg::word_t     data_addr_o,
	output core_pkg::word_t     data_o,
	output logic                data_req_o,
	output logic                data_wen_o,    // active low
	idex_if.execute             idex,
	exmem_if.execute            exmem
);

	core_pkg::fwd_sel_t fwd_a, fwd_b;
	core_pkg::word_t    mem_fwd_data; // value the mem-stage instr will write
	core_pkg::word_t    op_a, op_b;   // forwarded rs1/rs2
	core_pkg::word_t    alu_b;
	core_pkg::word_t    alu_result;
	logic               cond_met;

	// youngest producer wins; x0 is never bypassed
	function automatic core_pkg::fwd_sel_t fwd_pick(input core_pkg::reg_addr_t rs,
		input core_pkg::reg_addr_t mem_rd, input logic mem_we,
		input core_pkg::reg_addr_t wb_rd, input logic wb_we);
		if (mem_we && (mem_rd != '0) && (mem_rd == rs))
			fwd_pick = core_pkg::FWD_MEM;
		else if (wb_we && (wb_rd != '0) && (wb_rd == rs))
			fwd_pick = core_pkg::FWD_WB;
		else
			fwd_pick = core_pkg::FWD_NONE;
	endfunction

	assign fwd_a = fwd_pick(idex.rs1, exmem.rd, exmem.reg_write, wb_rd_i, wb_write_i);
	assign fwd_b = fwd_pick(idex.rs2, exmem.rd, exmem.reg_write, wb_rd_i, wb_write_i);

	// a load in mem never lands here, the load-use stall keeps it one stage back
	assign mem_fwd_data = (exmem.wb_sel == core_pkg::WB_LINK) ? exmem.link_pc
		: exmem.alu_result;

	always_comb
	begin
		case (fwd_a)
			core_pkg::FWD_MEM: op_a = mem_fwd_data;
			core_pkg::FWD_WB:  op_a = wb_data_i;
			default:           op_a = idex.rs1_data;
		endcase
		case (fwd_b)
			core_pkg::FWD_MEM: op_b = mem_fwd_data;
			core_pkg::FWD_WB:  op_b = wb_data_i;
			default:           op_b = idex.rs2_data;
		endcase
	end

	assign alu_b = idex.alu_src_imm ? idex.imm : op_b;

	always_comb
	begin
		case (idex.alu_op)
			core_pkg::ALU_ADD:    alu_result = op_a + alu_b;
			core_pkg::ALU_SUB:    alu_result = op_a - alu_b;
			core_pkg::ALU_AND:    alu_result = op_a & alu_b;
			core_pkg::ALU_OR:     alu_result = op_a | alu_b;
			core_pkg::ALU_XOR:    alu_result = op_a ^ alu_b;
			core_pkg::ALU_SLT:    alu_result = ($signed(op_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
			core_pkg::ALU_SLTU:   alu_result = (op_a < alu_b) ? 32'd1 : 32'd0;
			core_pkg::ALU_SLL:    alu_result = op_a << alu_b[4:0];  // low 5 bits only
			core_pkg::ALU_SRL:    alu_result = op_a >> alu_b[4:0];
			core_pkg::ALU_SRA:    alu_result = core_pkg::word_t'($signed(op_a) >>> alu_b[4:0]);
			core_pkg::ALU_PASS_B: alu_result = alu_b;               // lui
			default:              alu_result = '0;
		endcase
	end

	// branch compare on the register operands, not the alu
	always_comb
	begin
		case (idex.branch_cond)
			core_pkg::F3_BEQ: cond_met = (op_a == op_b);
			core_pkg::F3_BNE: cond_met = (op_a != op_b);
			core_pkg::F3_BLT: cond_met = ($signed(op_a) < $signed(op_b));
			default:          cond_met = 1'b0;
		endcase
	end

	assign redirect_o    = idex.valid && (idex.is_jump || (idex.is_branch && cond_met));
	assign redirect_pc_o = idex.pc + idex.imm; // pc-relative for both b and j

	// data request straight from ex, memory answers in mem
	assign data_addr_o = alu_result;
	assign data_o      = op_b;
	assign data_req_o  = idex.valid && (idex.mem_read || idex.mem_write);
	assign data_wen_o  = !(idex.valid && idex.mem_write);

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			exmem.rd        <= '0;
			exmem.reg_write <= 1'b0;
			exmem.mem_read  <= 1'b0;
			exmem.wb_sel    <= core_pkg::WB_ALU;
		end
		else
		begin
			exmem.rd        <= idex.rd;
			exmem.reg_write <= idex.valid && idex.reg_write;
			exmem.mem_read  <= idex.valid && idex.mem_read;
			exmem.wb_sel    <= idex.wb_sel;
		end
	end

	always_ff @(posedge clk_i)
	begin
		exmem.alu_result <= alu_result;
		exmem.link_pc    <= idex.pc + core_pkg::INSTR_BYTES; // jal return address
	end

endmodule

// File: src/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic                clk_i,
	input  logic                reset_i,
	input  core_pkg::word_t     data_i,     // dmem read data for the load in mem
	output logic                wb_write_o,
	output core_pkg::reg_addr_t wb_rd_o,
	output core_pkg::word_t     wb_data_o,
	exmem_if.memwb              exmem
);

	core_pkg::reg_addr_t rd_q;
	logic                reg_write_q;
	core_pkg::wb_sel_t   wb_sel_q;
	core_pkg::word_t     alu_q, link_q, load_q;

	// mem/wb control
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			rd_q        <= '0;
			reg_write_q <= 1'b0;
			wb_sel_q    <= core_pkg::WB_ALU;
		end
		else
		begin
			rd_q        <= exmem.rd;
			reg_write_q <= exmem.reg_write;
			wb_sel_q    <= exmem.wb_sel;
		end
	end

	// mem/wb payload
	always_ff @(posedge clk_i)
	begin
		alu_q  <= exmem.alu_result;
		link_q <= exmem.link_pc;
		if (exmem.mem_read)
			load_q <= data_i; // only capture on loads
	end

	// writeback select
	always_comb
	begin
		case (wb_sel_q)
			core_pkg::WB_MEM:  wb_data_o = load_q;
			core_pkg::WB_LINK: wb_data_o = link_q;
			default:           wb_data_o = alu_q;
		endcase
	end

	assign wb_write_o = reg_write_q;
	assign wb_rd_o    = rd_q;

endmodule

// File: src/core_top.sv
`timescale 1ns/1ps

module core_top (
	input  logic            clk_i,
	input  logic            reset_i,      // async, active low

	input  core_pkg::word_t instr_i,      // combinational imem data
	output core_pkg::word_t instr_addr_o,

	input  core_pkg::word_t data_i,       // read data, one cycle after request
	output core_pkg::word_t data_addr_o,
	output core_pkg::word_t data_o,
	output logic            data_req_o,
	output logic            data_wen_o    // active low
);

	core_pkg::word_t     ifid_instr, ifid_pc;
	logic                stall;                 // load-use hold from decode
	logic                redirect;              // taken branch or jal in ex
	core_pkg::word_t     redirect_pc;
	logic                wb_write;
	core_pkg::reg_addr_t wb_rd;
	core_pkg::word_t     wb_data;

	idex_if  u_idex ();
	exmem_if u_exmem ();

	fetch_stage u_fetch (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.instr_i       (instr_i),
		.stall_i       (stall),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.instr_addr_o  (instr_addr_o),
		.ifid_instr_o  (ifid_instr),
		.ifid_pc_o     (ifid_pc)
	);

	decode_stage u_decode (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.ifid_instr_i (ifid_instr),
		.ifid_pc_i    (ifid_pc),
		.redirect_i   (redirect),
		.wb_write_i   (wb_write),
		.wb_rd_i      (wb_rd),
		.wb_data_i    (wb_data),
		.stall_o      (stall),
		.idex         (u_idex.decode),
		.exmem        (u_exmem.hazard)
	);

	execute_stage u_execute (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.wb_write_i    (wb_write),
		.wb_rd_i       (wb_rd),
		.wb_data_i     (wb_data),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc),
		.data_addr_o   (data_addr_o),
		.data_o        (data_o),
		.data_req_o    (data_req_o),
		.data_wen_o    (data_wen_o),
		.idex          (u_idex.execute),
		.exmem         (u_exmem.execute)
	);

	mem_wb_stage u_mem_wb (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.data_i     (data_i),
		.wb_write_o (wb_write),
		.wb_rd_o    (wb_rd),
		.wb_data_o  (wb_data),
		.exmem      (u_exmem.memwb)
	);

endmodule

// File: include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program image with entry n at byte address 4*n
localparam int PROG_LEN    = 41;
localparam int STORE_COUNT = 13;

// two prefilled data words read back by the loads
localparam core_pkg::word_t PREFILL_A_ADDR = 32'h0000_0040;
localparam core_pkg::word_t PREFILL_A      = 32'h1234_5678;
localparam core_pkg::word_t PREFILL_B_ADDR = 32'h0000_0044;
localparam core_pkg::word_t PREFILL_B      = 32'hcafe_f00d;

// machine code with pc and assembly alongside
core_pkg::word_t program_table [PROG_LEN] = '{
	32'h0050_0093, // 00 addi x1,x0,5
	32'hffd0_0113, // 04 addi x2,x0,-3
	32'h0020_81b3, // 08 add  x3,x1,x2    x2 at distance 1, x1 at 2
	32'h4011_0233, // 0c sub  x4,x2,x1    x2 at 2, x1 at 3
	32'h0012_22b3, // 10 slt  x5,x4,x1
	32'h4032_5333, // 14 sra  x6,x4,x3
	32'h0830_2023, // 18 sw   x3,0x80(x0)
	32'h0840_2223, // 1c sw   x4,0x84(x0)
	32'h0850_2423, // 20 sw   x5,0x88(x0)
	32'h0860_2623, // 24 sw   x6,0x8c(x0)
	32'h00f2_4393, // 28 xori x7,x4,0xf
	32'h01c3_d413, // 2c srli x8,x7,28
	32'h0044_1493, // 30 slli x9,x8,4
	32'h0034_e533, // 34 or   x10,x9,x3
	32'h0075_75b3, // 38 and  x11,x10,x7
	32'h0020_b633, // 3c sltu x12,x1,x2
	32'h08b0_2823, // 40 sw   x11,0x90(x0)
	32'h08c0_2a23, // 44 sw   x12,0x94(x0)
	32'h1005_8693, // 48 addi x13,x11,0x100
	32'h08d0_2c23, // 4c sw   x13,0x98(x0)  data from the instr just before
	32'h0400_2703, // 50 lw   x14,0x40(x0)
	32'h0077_0793, // 54 addi x15,x14,7     load-use stall
	32'h08f0_2e23, // 58 sw   x15,0x9c(x0)
	32'h0010_8663, // 5c beq  x1,x1,+12     taken
	32'h0a10_2023, // 60 sw   x1,0xa0(x0)   squashed
	32'h0a20_2223, // 64 sw   x2,0xa4(x0)   squashed
	32'h0010_9463, // 68 bne  x1,x1,+8      not taken
	32'h0a30_2423, // 6c sw   x3,0xa8(x0)
	32'h00c0_086f, // 70 jal  x16,+12
	32'h0a10_2623, // 74 sw   x1,0xac(x0)   squashed
	32'h0a20_2823, // 78 sw   x2,0xb0(x0)   squashed
	32'h0b00_2a23, // 7c sw   x16,0xb4(x0)  link value
	32'h0370_0013, // 80 addi x0,x0,55      dropped write
	32'h0a00_2c23, // 84 sw   x0,0xb8(x0)
	32'habcd_e8b7, // 88 lui  x17,0xabcde
	32'h0b10_2e23, // 8c sw   x17,0xbc(x0)
	32'h0011_4463, // 90 blt  x2,x1,+8      -3 < 5 so taken
	32'h0c10_2023, // 94 sw   x1,0xc0(x0)   squashed
	32'h0440_2903, // 98 lw   x18,0x44(x0)
	32'h0d20_2223, // 9c sw   x18,0xc4(x0)  load-use on store data
	32'h0000_006f  // a0 jal  x0,0          parks the core
};

// expected stores in order as {byte address, data}
logic [63:0] store_table [STORE_COUNT] = '{
	{32'h0000_0080, 32'h0000_0002},      // 5 + -3
	{32'h0000_0084, 32'hffff_fff8},      // -3 - 5
	{32'h0000_0088, 32'h0000_0001},      // -8 < 5 signed
	{32'h0000_008c, 32'hffff_fffe},      // -8 >>> 2
	{32'h0000_0090, 32'h0000_00f2},      // (0xf0 | 2) & 0xfffffff7
	{32'h0000_0094, 32'h0000_0001},      // 5 < 0xfffffffd unsigned
	{32'h0000_0098, 32'h0000_01f2},
	{32'h0000_009c, PREFILL_A + 32'd7},
	{32'h0000_00a8, 32'h0000_0002},      // after the untaken bne
	{32'h0000_00b4, 32'h0000_0074},      // jal pc + 4
	{32'h0000_00b8, 32'h0000_0000},      // x0 stays zero
	{32'h0000_00bc, 32'habcd_e000},      // lui upper 20 bits
	{32'h0000_00c4, PREFILL_B}
};

`endif

// File: tb/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64; // byte addresses 0x00 to 0xff

	`include "tb_program.svh"

	localparam int CYCLE_LIMIT = 20 * PROG_LEN; // twenty cycles per program word

	logic            clk_i = 1'b0;
	logic            reset_i;
	core_pkg::word_t instr, instr_addr;
	core_pkg::word_t data_rd, data_addr, data_wr;
	logic            data_req, data_wen;

	core_pkg::word_t imem [IMEM_WORDS];
	core_pkg::word_t dmem [DMEM_WORDS];
	core_pkg::word_t read_q;      // read data waiting for its return cycle
	int              store_idx;   // next entry of store_table
	int              cycle_count;

	core_top UUT (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.instr_i      (instr),
		.instr_addr_o (instr_addr),
		.data_i       (data_rd),
		.data_addr_o  (data_addr),
		.data_o       (data_wr),
		.data_req_o   (data_req),
		.data_wen_o   (data_wen)
	);

	initial
	begin
		forever #5 clk_i = ~clk_i;
	end

	// nop outside the loaded range
	function automatic core_pkg::word_t fetch_word(input core_pkg::word_t addr);
		if (addr < IMEM_WORDS * 4)
			fetch_word = imem[addr[7:2]];
		else
			fetch_word = core_pkg::NOP_INSTR;
	endfunction

	task automatic load_memories();
		int i;
		for (i = 0; i < IMEM_WORDS; i++)
			imem[i[5:0]] = (i < PROG_LEN) ? program_table[i[5:0]] : core_pkg::NOP_INSTR;
		for (i = 0; i < DMEM_WORDS; i++)
			dmem[i[5:0]] = 32'hd00d_0000 ^ (core_pkg::word_t'(i) << 2); // byte address in the low bits
		dmem[PREFILL_A_ADDR[7:2]] = PREFILL_A;
		dmem[PREFILL_B_ADDR[7:2]] = PREFILL_B;
	endtask

	// compare one write against the next expected store
	task automatic check_store();
		core_pkg::word_t exp_addr;
		core_pkg::word_t exp_data;
		exp_addr = store_table[store_idx[3:0]][63:32];
		exp_data = store_table[store_idx[3:0]][31:0];
		assert ((data_addr == exp_addr) && (data_wr == exp_data))
		else
		begin
			$display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, store_idx, data_wr, data_addr, exp_data, exp_addr);
			$display("Test failed");
			$fatal(1, "store mismatch");
		end
		store_idx++;
	endtask

	// outputs while reset is still held
	task automatic verify_reset_outputs();
		assert ((instr_addr == core_pkg::RESET_VECTOR) &&
			(data_req == 1'b0) && (data_wen == 1'b1))
		else
		begin
			$display("[ERROR] %0t: in reset addr %h req %b wen %b, expected %h 0 1",
				$time, instr_addr, data_req, data_wen, core_pkg::RESET_VECTOR);
			$display("Test failed");
			$fatal(1, "reset state mismatch");
		end
	endtask

	// imem, dmem and store checks on the falling edge
	always @(negedge clk_i)
	begin
		cycle_count++;
		instr   = fetch_word(instr_addr); // answers this cycle's pc
		data_rd = read_q;                 // last cycle's read comes back
		if (data_req && data_wen)
			read_q = dmem[data_addr[7:2]];
		else if (data_req)
		begin
			check_store();
			dmem[data_addr[7:2]] = data_wr;
		end
	end

	initial
	begin
		reset_i     = 1'b0;
		instr       = core_pkg::NOP_INSTR;
		data_rd     = '0;
		read_q      = '0;
		store_idx   = 0;
		cycle_count = 0;
		load_memories();
		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		verify_reset_outputs();
		reset_i = 1'b1; // release between edges
		while ((store_idx < STORE_COUNT) && (cycle_count < CYCLE_LIMIT))
			@(posedge clk_i);
		if (store_idx == STORE_COUNT)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("timeout: stores not all seen");
			$display("Test failed");
			$fatal(1, "cycle limit reached");
		end
	end

endmodule

// File: build.f
+incdir+include
src/core_pkg.sv
src/core_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/core_top.sv
tb/core_tb.sv

// File: run.sh
#!/bin/sh
# build the core testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module core_tb -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -q "Test passed" ||
{ echo "simulation did not pass"; exit 1; }
